//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module rom_chk_tb -o rom_chk_sim
	./obj_dir/rom_chk_sim | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log

//--- bench/rom_chk_monitor.sv
module rom_chk_monitor
  import rom_chk_pkg::*;
#(
  parameter int NumWords = 2,
  parameter int RomDepth = 32,
  localparam int AddrW = $clog2(RomDepth)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             rom_req_i,
  input  logic [AddrW-1:0] rom_addr_i,
  input  word_t            rom_rdata_i,
  input  logic             rom_rvalid_i,
  input  axil_req_t        axil_req_i,
  input  axil_rsp_t        axil_rsp_i,
  input  logic             done_i,
  input  mubi4_t           good_i,
  input  logic             alert_i,
  output int               err_cnt_o
);

  localparam int DataWords = RomDepth - NumWords;

  // Digest lanes and expected words rebuilt from the ROM traffic
  word_t      lane_q [NumWords];
  word_t      exp_q  [NumWords];
  int         next_addr;
  int         req_addr;
  int         lane;
  logic       busy;
  logic       done_q;
  logic       alert_q;
  // Read response predicted at the address handshake
  word_t      rd_data;
  axil_resp_t rd_resp;
  int         errs = 0;

  assign err_cnt_o = errs;

  task automatic value_error(input string name, input word_t exp, input word_t got);
    $display("CHECK FAILED %s expected 0x%08h got 0x%08h", name, exp, got);
    errs++;
  endtask

  task automatic text_error(input string msg);
    $display("%s", msg);
    errs++;
  endtask

  // MuBi4True only when every lane equals its expected word
  function automatic mubi4_t good_model();
    logic all_eq;
    all_eq = 1'b1;
    for (int k = 0; k < NumWords; k++) begin
      if (lane_q[k] != exp_q[k]) begin
        all_eq = 1'b0;
      end
    end
    return all_eq ? MuBi4True : MuBi4False;
  endfunction

  // Register map as seen by software
  task automatic read_model(input axil_addr_t addr, output word_t data,
                            output axil_resp_t resp);
    int k;
    k = int'(addr[3:2]);
    data = '0;
    resp = RespSlvErr;
    if (addr == RegStatus) begin
      data = word_t'({1'b0, done_i ? good_model() : MuBi4False, done_i});
      resp = RespOkay;
    end else if ((addr[1:0] == 2'b00) && (k < NumWords)) begin
      if ((addr & 8'hf0) == RegDigest0) begin
        data = lane_q[k];
        resp = RespOkay;
      end else if ((addr & 8'hf0) == RegExpDigest0) begin
        data = exp_q[k];
        resp = RespOkay;
      end
    end
  endtask

  always @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int k = 0; k < NumWords; k++) begin
        lane_q[k] = '0;
        exp_q[k]  = '0;
      end
      next_addr = 0;
      busy      = 1'b0;
      done_q    = 1'b0;
      alert_q   = 1'b0;
    end else begin
      // Returned word goes to a lane or to the expected digest
      if (rom_rvalid_i) begin
        if (!busy) begin
          text_error("ROM data returned with no request pending");
        end else if (req_addr < DataWords) begin
          lane = req_addr % NumWords;
          lane_q[lane] = {lane_q[lane][26:0], lane_q[lane][31:27]} ^ rom_rdata_i ^
                         word_t'(req_addr);
        end else begin
          exp_q[req_addr - DataWords] = rom_rdata_i;
        end
        busy = 1'b0;
      end
      // In order, one outstanding
      if (rom_req_i) begin
        if (busy) begin
          text_error("ROM request issued while another one was outstanding");
        end
        if (int'(rom_addr_i) != next_addr) begin
          value_error("rom_addr_o", word_t'(next_addr), word_t'(rom_addr_i));
        end
        busy     = 1'b1;
        req_addr = int'(rom_addr_i);
        next_addr++;
      end
      // Result checked once at the rising edge of done
      if (done_i && !done_q) begin
        if (next_addr != RomDepth) begin
          text_error("check finished before the whole ROM was read");
        end
        if (good_i != good_model()) begin
          value_error("good_o", word_t'(good_model()), word_t'(good_i));
        end
      end
      if (!done_i && done_q) begin
        text_error("done_o fell without a reset");
      end
      if (alert_i && !alert_q) begin
        value_error("alert_o", 32'h0, 32'h1);
      end
      done_q  = done_i;
      alert_q = alert_i;
      // Bus side
      if (axil_req_i.ar_valid && axil_rsp_i.ar_ready) begin
        read_model(axil_req_i.ar_addr, rd_data, rd_resp);
      end
      if (axil_rsp_i.r_valid && axil_req_i.r_ready) begin
        if (axil_rsp_i.r_data != rd_data) begin
          value_error("r_data", rd_data, axil_rsp_i.r_data);
        end
        if (axil_rsp_i.r_resp != rd_resp) begin
          value_error("r_resp", word_t'(rd_resp), word_t'(axil_rsp_i.r_resp));
        end
      end
      // Read only register file
      if (axil_rsp_i.b_valid && axil_req_i.b_ready && (axil_rsp_i.b_resp != RespSlvErr)) begin
        value_error("b_resp", word_t'(RespSlvErr), word_t'(axil_rsp_i.b_resp));
      end
    end
  end

endmodule

//--- bench/rom_chk_tb.sv
module rom_chk_tb
  import rom_chk_pkg::*;
();

  localparam int NumWords    = 2;
  localparam int RomDepth    = 32;
  localparam int AddrW       = $clog2(RomDepth);
  localparam int DataWords   = RomDepth - NumWords;
  localparam int NumTests    = 12;
  // Up to 5 cycles per ROM word plus the compare
  localparam int DoneTimeout = RomDepth * 6 + 20;
  localparam int BusTimeout  = 16;

  logic             clk;
  logic             rst_n;
  logic             rom_req;
  logic [AddrW-1:0] rom_addr;
  word_t            rom_rdata = '0;
  logic             rom_rvalid = 1'b0;
  axil_req_t        axil_req;
  axil_rsp_t        axil_rsp;
  logic             done;
  mubi4_t           good;
  logic             alert;
  int               mon_errs;

  word_t       rom_mem [RomDepth];
  string       rom_kind;
  logic [31:0] lfsr_q = 32'h9277_559c;
  int          tb_errs = 0;
  // ROM responder state
  logic        rom_busy;
  int          rom_wait;
  int          rom_idx;

  rom_chk_top #(
    .NumWords(NumWords),
    .RomDepth(RomDepth)
  ) i_dut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .rom_req_o   (rom_req),
    .rom_addr_o  (rom_addr),
    .rom_rdata_i (rom_rdata),
    .rom_rvalid_i(rom_rvalid),
    .axil_req_i  (axil_req),
    .axil_rsp_o  (axil_rsp),
    .done_o      (done),
    .good_o      (good),
    .alert_o     (alert)
  );

  rom_chk_monitor #(
    .NumWords(NumWords),
    .RomDepth(RomDepth)
  ) i_mon (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .rom_req_i   (rom_req),
    .rom_addr_i  (rom_addr),
    .rom_rdata_i (rom_rdata),
    .rom_rvalid_i(rom_rvalid),
    .axil_req_i  (axil_req),
    .axil_rsp_i  (axil_rsp),
    .done_i      (done),
    .good_i      (good),
    .alert_i     (alert),
    .err_cnt_o   (mon_errs)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int b = 0; b < n; b++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
      val = {val[30:0], lfsr_q[0]};
    end
    return val;
  endfunction

  // ROM answers each request after 0 to 3 idle cycles
  always @(posedge clk) begin
    if (!rst_n) begin
      rom_rvalid <= 1'b0;
      rom_busy = 1'b0;
    end else begin
      rom_rvalid <= 1'b0;
      if (rom_req) begin
        rom_wait = int'(next_bits(2));
        rom_idx  = int'(rom_addr);
        rom_busy = 1'b1;
      end else if (rom_busy && (rom_wait > 0)) begin
        rom_wait--;
      end
      if (rom_busy && (rom_wait == 0)) begin
        rom_rvalid <= 1'b1;
        rom_rdata  <= rom_mem[rom_idx];
        rom_busy = 1'b0;
      end
    end
  end

  task automatic report_timeout(input string what);
    $display("timeout, %s", what);
    tb_errs++;
  endtask

  // Random contents
  // Odd tests get a top region that matches the fold
  task automatic fill_rom(input int test);
    word_t lanes [NumWords];
    int    k;
    for (int i = 0; i < RomDepth; i++) begin
      rom_mem[i] = next_bits(32);
    end
    rom_kind = "random top words";
    if (test % 2 == 1) begin
      for (int j = 0; j < NumWords; j++) begin
        lanes[j] = '0;
      end
      for (int i = 0; i < DataWords; i++) begin
        k = i % NumWords;
        lanes[k] = {lanes[k][26:0], lanes[k][31:27]} ^ rom_mem[i] ^ word_t'(i);
      end
      for (int j = 0; j < NumWords; j++) begin
        rom_mem[DataWords + j] = lanes[j];
      end
      rom_kind = "matching digest";
      if (next_bits(1) == 1) begin
        // Single bit flip in one expected word
        k = int'(next_bits(2)) % NumWords;
        rom_mem[DataWords + k] ^= word_t'(1) << next_bits(5);
        rom_kind = "corrupted digest";
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst_n    <= 1'b0;
    axil_req <= '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
  endtask

  task automatic wait_done();
    int t;
    t = 0;
    while (!done && (t < DoneTimeout)) begin
      @(posedge clk);
      t++;
    end
    if (!done) begin
      report_timeout("done_o never rose");
    end
  endtask

  // Address phase then a random rready delay while rvalid waits
  task automatic bus_read(input axil_addr_t addr);
    int t;
    int gap;
    gap = int'(next_bits(2));
    @(posedge clk);
    axil_req.ar_valid <= 1'b1;
    axil_req.ar_addr  <= addr;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!axil_rsp.ar_ready && (t < BusTimeout));
    axil_req.ar_valid <= 1'b0;
    if (!axil_rsp.ar_ready) begin
      report_timeout("read address never accepted");
      return;
    end
    repeat (gap) @(posedge clk);
    axil_req.r_ready <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!axil_rsp.r_valid && (t < BusTimeout));
    axil_req.r_ready <= 1'b0;
    if (!axil_rsp.r_valid) begin
      report_timeout("read response never came");
    end
  endtask

  // Address and data each held until their own ready
  // Then a random bready delay
  task automatic bus_write(input axil_addr_t addr, input word_t data);
    int   t;
    int   gap;
    logic aw_done;
    logic w_done;
    gap     = int'(next_bits(2));
    aw_done = 1'b0;
    w_done  = 1'b0;
    @(posedge clk);
    axil_req.aw_valid <= 1'b1;
    axil_req.aw_addr  <= addr;
    axil_req.w_valid  <= 1'b1;
    axil_req.w_data   <= data;
    axil_req.w_strb   <= 4'hf;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (axil_rsp.aw_ready) begin
        aw_done = 1'b1;
        axil_req.aw_valid <= 1'b0;
      end
      if (axil_rsp.w_ready) begin
        w_done = 1'b1;
        axil_req.w_valid <= 1'b0;
      end
    end while (!(aw_done && w_done) && (t < BusTimeout));
    axil_req.aw_valid <= 1'b0;
    axil_req.w_valid  <= 1'b0;
    if (!(aw_done && w_done)) begin
      report_timeout("write address or data never accepted");
      return;
    end
    repeat (gap) @(posedge clk);
    axil_req.b_ready <= 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
    end while (!axil_rsp.b_valid && (t < BusTimeout));
    axil_req.b_ready <= 1'b0;
    if (!axil_rsp.b_valid) begin
      report_timeout("write response never came");
    end
  endtask

  initial begin
    int fails;
    int mon_before;
    int tb_before;
    rst_n    = 1'b0;
    axil_req = '0;
    fails    = 0;
    for (int test = 0; test < NumTests; test++) begin
      // Error window runs from here to the verdict of this test
      mon_before = mon_errs;
      tb_before  = tb_errs;
      fill_rom(test);
      apply_reset();
      @(negedge clk);
      wait_done();
      // Write first so the reads also show that nothing changed
      bus_write(axil_addr_t'(next_bits(8)), next_bits(32));
      bus_read(RegStatus);
      for (int k = 0; k < 4; k++) begin
        bus_read(RegDigest0 + axil_addr_t'(4 * k));
        bus_read(RegExpDigest0 + axil_addr_t'(4 * k));
      end
      // Unmapped and misaligned
      bus_read(8'h30);
      bus_read(8'h11);
      bus_read(axil_addr_t'(next_bits(8)));
      repeat (2) @(posedge clk);
      @(negedge clk);
      if ((mon_errs == mon_before) && (tb_errs == tb_before)) begin
        $display("test %0d (%s) ok", test, rom_kind);
      end else begin
        fails++;
        $display("test %0d (%s) FAILED", test, rom_kind);
      end
    end
    $display("%0d tests, %0d passed, %0d failed", NumTests, NumTests - fails, fails);
    if (fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- rtl/rom_chk_compare.sv
module rom_chk_compare
  import rom_chk_pkg::*;
#(
  parameter int NumWords = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 start_i,
  output logic                 done_o,
  output mubi4_t               good_o,
  input  word_t [NumWords-1:0] digest_i,
  input  word_t [NumWords-1:0] exp_digest_i,
  output logic                 alert_o
);

  localparam int CntW = (NumWords > 1) ? $clog2(NumWords) : 1;
  localparam logic [CntW-1:0] LastCnt = CntW'(NumWords - 1);

  // Sparse encoding, every pair of states at least 3 bits apart
  typedef enum logic [4:0] {
    Waiting  = 5'b00100,
    Checking = 5'b10010,
    Done     = 5'b11001
  } state_e;

  state_e          state_q, state_d;
  logic [CntW-1:0] cnt_q;
  logic            matches_q, matches_d;
  logic            word_match;
  mubi4_t          good_q, good_d;
  logic            fsm_alert;
  logic            start_alert;
  logic            wait_cnt_alert;
  logic            done_cnt_alert;
  logic            alert_q;

  always_comb begin
    state_d   = state_q;
    fsm_alert = 1'b0;
    unique case (state_q)
      Waiting: begin
        if (start_i) begin
          state_d = Checking;
        end
      end
      Checking: begin
        // One word per cycle
        if (cnt_q == LastCnt) begin
          state_d = Done;
        end
      end
      Done: begin
        // Terminal
        state_d = Done;
      end
      default: begin
        fsm_alert = 1'b1;
      end
    endcase
  end

  // Control flow and counter consistency
  assign start_alert    = start_i && (state_q != Waiting);
  assign wait_cnt_alert = (state_q == Waiting) && (cnt_q != '0);
  assign done_cnt_alert = (state_q == Done) && (cnt_q != LastCnt);

  // Current word pair
  assign word_match = digest_i[cnt_q] == exp_digest_i[cnt_q];

  always_comb begin
    matches_d = matches_q;
    if (state_q == Checking) begin
      matches_d = matches_q && word_match;
    end
  end

  // Good only once the last word has been checked
  assign good_d = ((state_d == Done) && matches_d) ? MuBi4True : MuBi4False;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= Waiting;
      cnt_q     <= '0;
      matches_q <= 1'b1;
      good_q    <= MuBi4False;
      alert_q   <= 1'b0;
    end else begin
      state_q   <= state_d;
      matches_q <= matches_d;
      good_q    <= good_d;
      // Stays high once raised
      alert_q   <= alert_q | fsm_alert | start_alert | wait_cnt_alert | done_cnt_alert;
      if ((state_q == Checking) && (cnt_q != LastCnt)) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end
  end

  assign done_o  = state_q == Done;
  assign good_o  = good_q;
  assign alert_o = alert_q;

  // Done is final for the life of a reset
  done_sticky_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    done_o |=> done_o);

endmodule

//--- rtl/rom_chk_digest.sv
module rom_chk_digest
  import rom_chk_pkg::*;
#(
  parameter int NumWords = 2,
  parameter int RomDepth = 32,
  localparam int AddrW = $clog2(RomDepth)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 word_valid_i,
  input  word_t                word_data_i,
  input  logic [AddrW-1:0]     word_idx_i,
  output word_t [NumWords-1:0] digest_o
);

  localparam int LaneW = (NumWords > 1) ? $clog2(NumWords) : 1;

  word_t [NumWords-1:0] lane_q;
  logic [AddrW-1:0]     lane_full;
  logic [LaneW-1:0]     lane_sel;
  word_t                lane_rot;
  word_t                folded;

  // Words are spread round robin over the lanes
  assign lane_full = word_idx_i % AddrW'(NumWords);
  assign lane_sel  = lane_full[LaneW-1:0];

  // Rotate left by 5
  assign lane_rot = {lane_q[lane_sel][26:0], lane_q[lane_sel][31:27]};

  // Index folded in so that swapped words change the digest
  assign folded = lane_rot ^ word_data_i ^ word_t'(word_idx_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lane_q <= '0;
    end else if (word_valid_i) begin
      lane_q[lane_sel] <= folded;
    end
  end

  assign digest_o = lane_q;

  // Only data words may reach the digest, never the expected region
  idx_in_data_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    word_valid_i |-> int'(word_idx_i) < RomDepth - NumWords);

endmodule

//--- rtl/rom_chk_fetch.sv
module rom_chk_fetch
  import rom_chk_pkg::*;
#(
  parameter int NumWords = 2,
  parameter int RomDepth = 32,
  localparam int AddrW = $clog2(RomDepth)
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // ROM read port
  output logic                 rom_req_o,
  output logic [AddrW-1:0]     rom_addr_o,
  input  word_t                rom_rdata_i,
  input  logic                 rom_rvalid_i,
  // Data words to the digest
  output logic                 word_valid_o,
  output word_t                word_data_o,
  output logic [AddrW-1:0]     word_idx_o,
  // Expected digest and compare trigger
  output word_t [NumWords-1:0] exp_digest_o,
  output logic                 cmp_start_o
);

  localparam int ExpW = (NumWords > 1) ? $clog2(NumWords) : 1;
  // First address of the expected digest region
  localparam logic [AddrW-1:0] FirstExp = AddrW'(RomDepth - NumWords);
  localparam logic [AddrW-1:0] LastAddr = AddrW'(RomDepth - 1);

  typedef enum logic [1:0] {
    Idle,
    Request,
    Wait,
    Finish
  } state_e;

  state_e               state_q, state_d;
  logic [AddrW-1:0]     addr_q;
  logic                 start_q;
  logic                 rx;
  logic                 is_data;
  logic                 last_word;
  logic [AddrW-1:0]     exp_idx;
  word_t [NumWords-1:0] exp_q;

  // Response for the single outstanding request
  assign rx        = (state_q == Wait) && rom_rvalid_i;
  assign is_data   = addr_q < FirstExp;
  assign last_word = addr_q == LastAddr;
  assign exp_idx   = addr_q - FirstExp;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      Idle: begin
        state_d = Request;
      end
      Request: begin
        state_d = Wait;
      end
      Wait: begin
        // Next request goes out in the cycle after rvalid
        if (rom_rvalid_i) begin
          state_d = last_word ? Finish : Request;
        end
      end
      Finish: begin
        // Whole ROM read, stay here until reset
        state_d = Finish;
      end
      default: begin
        state_d = Idle;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= Idle;
      addr_q  <= '0;
      start_q <= 1'b0;
    end else begin
      state_q <= state_d;
      // Single pulse one cycle after the last word
      start_q <= rx && last_word;
      if (rx && !last_word) begin
        addr_q <= addr_q + 1'b1;
      end
    end
  end

  // Top words of the ROM form the expected digest
  always_ff @(posedge clk_i) begin
    if (rx && !is_data) begin
      exp_q[exp_idx[ExpW-1:0]] <= rom_rdata_i;
    end
  end

  assign rom_req_o    = state_q == Request;
  assign rom_addr_o   = addr_q;
  assign word_valid_o = rx && is_data;
  assign word_data_o  = rom_rdata_i;
  assign word_idx_o   = addr_q;
  assign exp_digest_o = exp_q;
  assign cmp_start_o  = start_q;

  // ROM must only answer a request that is actually pending
  rvalid_in_wait_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rom_rvalid_i |-> state_q == Wait);

endmodule

//--- rtl/rom_chk_pkg.sv
package rom_chk_pkg;

  // ROM data and digest words
  typedef logic [31:0] word_t;

  // Multi-bit boolean, single bit flips never produce a valid value
  typedef logic [3:0] mubi4_t;
  localparam mubi4_t MuBi4True  = 4'h6;
  localparam mubi4_t MuBi4False = 4'h9;

  // Bus address and response
  typedef logic [7:0] axil_addr_t;
  typedef logic [1:0] axil_resp_t;

  localparam axil_resp_t RespOkay   = 2'b00;
  localparam axil_resp_t RespSlvErr = 2'b10;

  // Register map, one word every 4 bytes
  localparam axil_addr_t RegStatus     = 8'h00;
  localparam axil_addr_t RegDigest0    = 8'h10;
  localparam axil_addr_t RegExpDigest0 = 8'h20;

  // Master to slave
  typedef struct packed {
    logic       aw_valid;
    axil_addr_t aw_addr;
    logic       w_valid;
    word_t      w_data;
    logic [3:0] w_strb;
    logic       b_ready;
    logic       ar_valid;
    axil_addr_t ar_addr;
    logic       r_ready;
  } axil_req_t;

  // Slave to master
  typedef struct packed {
    logic       aw_ready;
    logic       w_ready;
    logic       b_valid;
    axil_resp_t b_resp;
    logic       ar_ready;
    logic       r_valid;
    word_t      r_data;
    axil_resp_t r_resp;
  } axil_rsp_t;

endpackage

//--- rtl/rom_chk_regs.sv
module rom_chk_regs
  import rom_chk_pkg::*;
#(
  parameter int NumWords = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  axil_req_t            axil_req_i,
  output axil_rsp_t            axil_rsp_o,
  input  logic                 done_i,
  input  mubi4_t               good_i,
  input  logic                 alert_i,
  input  word_t [NumWords-1:0] digest_i,
  input  word_t [NumWords-1:0] exp_digest_i
);

  logic       r_valid_q;
  word_t      r_data_q;
  axil_resp_t r_resp_q;
  logic       b_valid_q;
  logic       alert_seen_q;
  logic       rd_hs;
  logic       wr_hs;
  axil_addr_t rd_addr;
  logic [1:0] rd_widx;
  logic       rd_widx_ok;
  word_t      rd_data;
  axil_resp_t rd_resp;

  // One read in flight, a new address only after the data left
  assign rd_hs = axil_req_i.ar_valid && !r_valid_q;

  // Address and data taken together, nothing is written
  assign wr_hs = axil_req_i.aw_valid && axil_req_i.w_valid && !b_valid_q;

  assign rd_addr    = axil_req_i.ar_addr;
  assign rd_widx    = rd_addr[3:2];
  assign rd_widx_ok = int'(rd_widx) < NumWords;

  // Read decode
  always_comb begin
    rd_data = '0;
    rd_resp = RespSlvErr;
    if (rd_addr[1:0] == 2'b00) begin
      if (rd_addr == RegStatus) begin
        rd_data = word_t'({alert_seen_q, good_i, done_i});
        rd_resp = RespOkay;
      end else if (((rd_addr & 8'hf0) == RegDigest0) && rd_widx_ok) begin
        rd_data = digest_i[rd_widx];
        rd_resp = RespOkay;
      end else if (((rd_addr & 8'hf0) == RegExpDigest0) && rd_widx_ok) begin
        rd_data = exp_digest_i[rd_widx];
        rd_resp = RespOkay;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q    <= 1'b0;
      b_valid_q    <= 1'b0;
      alert_seen_q <= 1'b0;
    end else begin
      alert_seen_q <= alert_seen_q | alert_i;
      // Response held until the master takes it
      if (rd_hs) begin
        r_valid_q <= 1'b1;
      end else if (axil_req_i.r_ready) begin
        r_valid_q <= 1'b0;
      end
      if (wr_hs) begin
        b_valid_q <= 1'b1;
      end else if (axil_req_i.b_ready) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // Read data captured at address handshake
  always_ff @(posedge clk_i) begin
    if (rd_hs) begin
      r_data_q <= rd_data;
      r_resp_q <= rd_resp;
    end
  end

  always_comb begin
    axil_rsp_o          = '0;
    axil_rsp_o.aw_ready = wr_hs;
    axil_rsp_o.w_ready  = wr_hs;
    axil_rsp_o.b_valid  = b_valid_q;
    // Register file is read only
    axil_rsp_o.b_resp   = RespSlvErr;
    axil_rsp_o.ar_ready = !r_valid_q;
    axil_rsp_o.r_valid  = r_valid_q;
    axil_rsp_o.r_data   = r_data_q;
    axil_rsp_o.r_resp   = r_resp_q;
  end

  // Read response must not be dropped or change under back-pressure
  r_hold_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_valid_q && !axil_req_i.r_ready |=> r_valid_q && $stable(r_data_q));

endmodule

//--- rtl/rom_chk_top.sv
module rom_chk_top
  import rom_chk_pkg::*;
#(
  parameter int NumWords = 2,
  parameter int RomDepth = 32,
  localparam int AddrW = $clog2(RomDepth)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // ROM
  output logic             rom_req_o,
  output logic [AddrW-1:0] rom_addr_o,
  input  word_t            rom_rdata_i,
  input  logic             rom_rvalid_i,
  // Register bus
  input  axil_req_t        axil_req_i,
  output axil_rsp_t        axil_rsp_o,
  // Check result
  output logic             done_o,
  output mubi4_t           good_o,
  output logic             alert_o
);

  logic                 word_valid;
  word_t                word_data;
  logic [AddrW-1:0]     word_idx;
  word_t [NumWords-1:0] digest;
  word_t [NumWords-1:0] exp_digest;
  logic                 cmp_start;

  // ROM sequencer
  rom_chk_fetch #(
    .NumWords(NumWords),
    .RomDepth(RomDepth)
  ) u_fetch (
    .clk_i,
    .rst_ni,
    .rom_req_o,
    .rom_addr_o,
    .rom_rdata_i,
    .rom_rvalid_i,
    .word_valid_o(word_valid),
    .word_data_o (word_data),
    .word_idx_o  (word_idx),
    .exp_digest_o(exp_digest),
    .cmp_start_o (cmp_start)
  );

  rom_chk_digest #(
    .NumWords(NumWords),
    .RomDepth(RomDepth)
  ) u_digest (
    .clk_i,
    .rst_ni,
    .word_valid_i(word_valid),
    .word_data_i (word_data),
    .word_idx_i  (word_idx),
    .digest_o    (digest)
  );

  rom_chk_compare #(
    .NumWords(NumWords)
  ) u_compare (
    .clk_i,
    .rst_ni,
    .start_i     (cmp_start),
    .done_o,
    .good_o,
    .digest_i    (digest),
    .exp_digest_i(exp_digest),
    .alert_o
  );

  // Software view of status and both digests
  rom_chk_regs #(
    .NumWords(NumWords)
  ) u_regs (
    .clk_i,
    .rst_ni,
    .axil_req_i,
    .axil_rsp_o,
    .done_i      (done_o),
    .good_i      (good_o),
    .alert_i     (alert_o),
    .digest_i    (digest),
    .exp_digest_i(exp_digest)
  );

endmodule

//--- src.f
rtl/rom_chk_pkg.sv
rtl/rom_chk_fetch.sv
rtl/rom_chk_digest.sv
rtl/rom_chk_compare.sv
rtl/rom_chk_regs.sv
rtl/rom_chk_top.sv
bench/rom_chk_monitor.sv
bench/rom_chk_tb.sv
